// ==== compile.f ====
+incdir+hdl
hdl/soc_bus_pkg.sv
hdl/soc_csr_pkg.sv
hdl/reset_gen.sv
hdl/axil_host_bridge.sv
hdl/mem_arbiter.sv
hdl/frame_ram.sv
hdl/frame_fetch.sv
hdl/sys_ctl.sv
hdl/soc_top.sv
testbench/tb_soc_top.sv

// ==== Bender.yml ====
package:
  name: video_soc_core

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/soc_bus_pkg.sv
      - hdl/soc_csr_pkg.sv
      - hdl/reset_gen.sv
      - hdl/axil_host_bridge.sv
      - hdl/mem_arbiter.sv
      - hdl/frame_ram.sv
      - hdl/frame_fetch.sv
      - hdl/sys_ctl.sv
      - hdl/soc_top.sv
  - target: test
    files:
      - testbench/tb_soc_top.sv

// ==== testbench/tb_soc_top.sv ====
// Self-checking testbench for the video SoC core, table-driven over the AXI4-Lite host port
`timescale 1ns/10ps
`include "soc_config.svh"

module tb_soc_top;

	typedef enum int {
		OP_IDLE, OP_MWR, OP_MRD, OP_FILL, OP_CWR, OP_CRD, OP_BTN, OP_LED, OP_FETCH, OP_SRST
	} op_e;

	logic        sys_clk;
	logic        trigger_reset;
	logic [31:0] awaddr_i;
	logic        awvalid_i;
	logic        awready_o;
	logic [31:0] wdata_i;
	logic [3:0]  wstrb_i;
	logic        wvalid_i;
	logic        wready_o;
	logic [1:0]  bresp_o;
	logic        bvalid_o;
	logic        bready_i;
	logic [31:0] araddr_i;
	logic        arvalid_i;
	logic        arready_o;
	logic [31:0] rdata_o;
	logic [1:0]  rresp_o;
	logic        rvalid_o;
	logic        rready_i;
	logic [2:0]  btn_i;
	logic [1:0]  led_o;
	logic [31:0] pixel_o;
	logic        pixel_valid_o;
	logic        pixel_ready_i;

	// Stimulus table, one entry per test
	op_e         op_q[$];
	string       name_q[$];
	logic [31:0] addr_q[$];
	logic [31:0] data_q[$];
	logic [3:0]  strb_q[$];
	logic [31:0] exp_q[$];
	logic [1:0]  resp_q[$];

	logic [31:0] model [0:(1 << `MEM_AW)-1];
	logic [31:0] pix_q[$];
	logic [31:0] data_lfsr;
	logic [31:0] ready_lfsr;
	int          err_cnt;
	int          chk_cnt;
	int          fail_cnt;
	int          cycle_cnt;
	int          cycle_limit;

	soc_top u_soc_top (.*);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// Run limit from the length of the table
	always @(posedge sys_clk) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// Random sink back-pressure and pixel capture
	always @(negedge sys_clk) begin
		ready_lfsr = lfsr_step(ready_lfsr);
		pixel_ready_i = ready_lfsr[0];
		if (pixel_valid_o && pixel_ready_i)
			pix_q.push_back(pixel_o);
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			data_lfsr = lfsr_step(data_lfsr);
			v = {v[30:0], data_lfsr[0]};
		end
		take_bits = v;
	endfunction

	function automatic logic [31:0] csr_addr(input logic [3:0] blk, input logic [1:0] rg);
		csr_addr = (32'd1 << `CSR_REGION_BIT) | {24'd0, blk, rg, 2'b00};
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("ERROR %s: expected %08h, actual %08h", name, exp, act);
		end
	endtask

	task automatic add_test(input op_e op, input string name, input logic [31:0] addr,
			input logic [31:0] data, input logic [3:0] strb, input logic [31:0] exp,
			input logic [1:0] resp);
		op_q.push_back(op);
		name_q.push_back(name);
		addr_q.push_back(addr);
		data_q.push_back(data);
		strb_q.push_back(strb);
		exp_q.push_back(exp);
		resp_q.push_back(resp);
	endtask

	// --------------------------------------------------
	// AXI4-Lite master tasks
	// --------------------------------------------------
	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		int stall;
		@(negedge sys_clk);
		awaddr_i  = addr;
		wdata_i   = data;
		wstrb_i   = strb;
		awvalid_i = 1'b1;
		wvalid_i  = 1'b1;
		@(negedge sys_clk);
		while (!(awready_o && wready_o)) @(negedge sys_clk);
		// Handshake on the coming rising edge
		@(negedge sys_clk);
		awvalid_i = 1'b0;
		wvalid_i  = 1'b0;
		while (!bvalid_o) @(negedge sys_clk);
		resp  = bresp_o;
		stall = take_bits(2);
		repeat (stall) @(negedge sys_clk);
		bready_i = 1'b1;
		@(negedge sys_clk);
		bready_i = 1'b0;
	endtask

	task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int stall;
		@(negedge sys_clk);
		araddr_i  = addr;
		arvalid_i = 1'b1;
		@(negedge sys_clk);
		while (!arready_o) @(negedge sys_clk);
		@(negedge sys_clk);
		arvalid_i = 1'b0;
		while (!rvalid_o) @(negedge sys_clk);
		data  = rdata_o;
		resp  = rresp_o;
		stall = take_bits(2);
		repeat (stall) @(negedge sys_clk);
		rready_i = 1'b1;
		@(negedge sys_clk);
		rready_i = 1'b0;
	endtask

	task automatic merge_model(input int idx, input logic [31:0] data, input logic [3:0] strb);
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				model[idx][8*b +: 8] = data[8*b +: 8];
		end
	endtask

	// Scan-out run with host reads interleaved
	task automatic run_fetch(input int i);
		logic [31:0] rd;
		logic [1:0]  resp;
		int          base;
		int          cnt;
		int          off;
		base = addr_q[i];
		cnt  = data_q[i];
		pix_q.delete();
		axi_write(csr_addr(soc_csr_pkg::FETCH, soc_csr_pkg::BASE), base, 4'hF, resp);
		axi_write(csr_addr(soc_csr_pkg::FETCH, soc_csr_pkg::COUNT), cnt, 4'hF, resp);
		axi_write(csr_addr(soc_csr_pkg::FETCH, soc_csr_pkg::CTRL), 32'd1, 4'hF, resp);
		check({name_q[i], " start bresp"}, soc_bus_pkg::OKAY, resp);
		while (pix_q.size() < cnt) begin
			off = take_bits(3) % cnt;
			axi_read((base + off) << 2, rd, resp);
			check({name_q[i], " host read"}, model[base + off], rd);
			axi_read(csr_addr(soc_csr_pkg::FETCH, soc_csr_pkg::CTRL), rd, resp);
			// Words still missing, so the engine was busy when sampled
			if (pix_q.size() < cnt)
				check({name_q[i], " busy"}, 32'd1, rd);
		end
		repeat (4) @(negedge sys_clk);
		axi_read(csr_addr(soc_csr_pkg::FETCH, soc_csr_pkg::CTRL), rd, resp);
		check({name_q[i], " idle"}, 32'd0, rd);
		check({name_q[i], " word count"}, cnt, pix_q.size());
		for (int p = 0; p < cnt && p < pix_q.size(); p++)
			check($sformatf("%s pixel %0d", name_q[i], p), model[base + p], pix_q[p]);
	endtask

	task automatic run_test(input int i);
		logic [31:0] rd;
		logic [31:0] wd;
		logic [1:0]  resp;
		int          idx;
		string       nm;
		nm  = name_q[i];
		idx = addr_q[i][`MEM_AW+1:2];
		case (op_q[i])
			OP_MWR: begin
				wd = take_bits(32);
				axi_write(addr_q[i], wd, strb_q[i], resp);
				check({nm, " bresp"}, resp_q[i], resp);
				if (resp_q[i] == soc_bus_pkg::OKAY)
					merge_model(idx, wd, strb_q[i]);
			end
			OP_MRD, OP_CRD: begin
				axi_read(addr_q[i], rd, resp);
				check({nm, " rresp"}, resp_q[i], resp);
				if (op_q[i] == OP_CRD)
					check({nm, " rdata"}, exp_q[i], rd);
				else if (resp_q[i] == soc_bus_pkg::OKAY)
					check({nm, " rdata"}, model[idx], rd);
			end
			OP_FILL: begin
				for (int w = 0; w < data_q[i]; w++) begin
					wd = take_bits(32);
					axi_write(addr_q[i] + 4 * w, wd, 4'hF, resp);
					check({nm, " bresp"}, soc_bus_pkg::OKAY, resp);
					model[idx + w] = wd;
				end
			end
			OP_CWR: begin
				axi_write(addr_q[i], data_q[i], 4'hF, resp);
				check({nm, " bresp"}, resp_q[i], resp);
			end
			OP_BTN: begin
				@(negedge sys_clk);
				btn_i = data_q[i][2:0];
			end
			OP_LED: begin
				@(negedge sys_clk);
				check({nm, " led"}, exp_q[i], led_o);
			end
			OP_IDLE: begin
				@(negedge sys_clk);
				check({nm, " outputs"}, 32'd0, {awready_o, wready_o, arready_o, bvalid_o,
						rvalid_o, pixel_valid_o, led_o});
			end
			OP_FETCH: run_fetch(i);
			OP_SRST: begin
				// Restart the scan-out so the reset has a run in flight to abort
				axi_write(csr_addr(soc_csr_pkg::FETCH, soc_csr_pkg::CTRL), 32'd1, 4'hF, resp);
				axi_write(csr_addr(soc_csr_pkg::SYSCTL, soc_csr_pkg::SOFT_RESET), 32'd1, 4'hF,
						resp);
				repeat (3 * `RST_HOLD) @(negedge sys_clk);
				check({nm, " led"}, 32'd0, led_o);
				check({nm, " pixel valid"}, 32'd0, pixel_valid_o);
				axi_read(csr_addr(soc_csr_pkg::FETCH, soc_csr_pkg::CTRL), rd, resp);
				check({nm, " busy"}, 32'd0, rd);
			end
			default: begin
				err_cnt++;
				$display("Test %s has an unknown operation", nm);
			end
		endcase
	endtask

	// --------------------------------------------------
	// Test table
	// --------------------------------------------------
	task automatic build_table();
		logic [1:0] ok;
		logic [1:0] de;
		ok = soc_bus_pkg::OKAY;
		de = soc_bus_pkg::DECERR;
		add_test(OP_IDLE,  "reset_idle",      0, 0, 0, 0, ok);
		add_test(OP_CRD,   "fetch_not_busy",
				csr_addr(soc_csr_pkg::FETCH, soc_csr_pkg::CTRL), 0, 0, 0, ok);
		add_test(OP_FILL,  "mem_fill_low",    32'h000, 4, 0, 0, ok);
		add_test(OP_MRD,   "mem_read_w0",     32'h000, 0, 0, 0, ok);
		add_test(OP_MWR,   "mem_strb_0101",   32'h004, 0, 4'b0101, 0, ok);
		add_test(OP_MWR,   "mem_strb_1000",   32'h008, 0, 4'b1000, 0, ok);
		add_test(OP_MWR,   "mem_strb_0110",   32'h00C, 0, 4'b0110, 0, ok);
		add_test(OP_MWR,   "mem_strb_none",   32'h000, 0, 4'b0000, 0, ok);
		add_test(OP_MRD,   "mem_merge_w0",    32'h000, 0, 0, 0, ok);
		add_test(OP_MRD,   "mem_merge_w1",    32'h004, 0, 0, 0, ok);
		add_test(OP_MRD,   "mem_merge_w2",    32'h008, 0, 0, 0, ok);
		add_test(OP_MRD,   "mem_merge_w3",    32'h00C, 0, 0, 0, ok);
		add_test(OP_MWR,   "mem_write_range", 32'h3004, 0, 4'hF, 0, de);
		add_test(OP_MRD,   "mem_read_range",  32'h8008, 0, 0, 0, de);
		add_test(OP_MRD,   "mem_alias_kept",  32'h004, 0, 0, 0, ok);
		add_test(OP_CRD,   "system_id",
				csr_addr(soc_csr_pkg::SYSCTL, soc_csr_pkg::SYSTEM_ID), 0, 0, `SYSTEM_ID, ok);
		add_test(OP_BTN,   "buttons_drive",   0, 3'b101, 0, 0, ok);
		add_test(OP_CRD,   "gpio_in",
				csr_addr(soc_csr_pkg::SYSCTL, soc_csr_pkg::GPIO_IN), 0, 0, 3'b101, ok);
		add_test(OP_CWR,   "gpio_out_write",
				csr_addr(soc_csr_pkg::SYSCTL, soc_csr_pkg::GPIO_OUT), 2'b10, 0, 0, ok);
		add_test(OP_LED,   "led_pins",        0, 0, 0, 2'b10, ok);
		add_test(OP_CRD,   "gpio_out_read",
				csr_addr(soc_csr_pkg::SYSCTL, soc_csr_pkg::GPIO_OUT), 0, 0, 2'b10, ok);
		add_test(OP_CRD,   "csr_unused_block", csr_addr(4'd2, 2'd0), 0, 0, 0, ok);
		add_test(OP_FILL,  "fetch_fill",      32'h080, 8, 0, 0, ok);
		add_test(OP_MWR,   "fetch_strb_0011", 32'h088, 0, 4'b0011, 0, ok);
		add_test(OP_FETCH, "fetch_run",       32'h020, 8, 0, 0, ok);
		add_test(OP_CRD,   "fetch_count_read",
				csr_addr(soc_csr_pkg::FETCH, soc_csr_pkg::COUNT), 0, 0, 8, ok);
		add_test(OP_SRST,  "soft_reset",      0, 0, 0, 0, ok);
		add_test(OP_CRD,   "system_id_again",
				csr_addr(soc_csr_pkg::SYSCTL, soc_csr_pkg::SYSTEM_ID), 0, 0, `SYSTEM_ID, ok);
		add_test(OP_IDLE,  "idle_after_reset", 0, 0, 0, 0, ok);
	endtask

	initial begin
		int errs_before;
		trigger_reset = 1'b1;
		awaddr_i      = '0;
		awvalid_i     = 1'b0;
		wdata_i       = '0;
		wstrb_i       = '0;
		wvalid_i      = 1'b0;
		bready_i      = 1'b0;
		araddr_i      = '0;
		arvalid_i     = 1'b0;
		rready_i      = 1'b0;
		btn_i         = '0;
		pixel_ready_i = 1'b0;
		data_lfsr     = 32'h6686_f2d6;
		ready_lfsr    = 32'h6686_f2d6;
		err_cnt       = 0;
		chk_cnt       = 0;
		fail_cnt      = 0;
		cycle_cnt     = 0;
		build_table();
		cycle_limit = 40 * op_q.size() + 4 * `RST_HOLD;
		foreach (op_q[i]) begin
			if (op_q[i] == OP_FETCH)
				cycle_limit += 20 * data_q[i];
		end

		repeat (4) @(negedge sys_clk);
		trigger_reset = 1'b0;
		repeat (`RST_HOLD + 4) @(negedge sys_clk);

		foreach (op_q[i]) begin
			errs_before = err_cnt;
			run_test(i);
			if (err_cnt == errs_before) begin
				$display("PASS %s", name_q[i]);
			end else begin
				fail_cnt++;
				$display("FAIL %s", name_q[i]);
			end
		end

		$display("Tests: %0d, passed: %0d, failed: %0d, checks: %0d, errors: %0d",
				op_q.size(), op_q.size() - fail_cnt, fail_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== hdl/soc_top.sv ====
// Video SoC core top: reset, host bridge, memory arbiter, frame RAM and CSR peers
`timescale 1ns/10ps

module soc_top (
	input  logic                   sys_clk,
	input  logic                   trigger_reset,
	// AXI4-Lite host port
	input  logic [31:0]            awaddr_i,
	input  logic                   awvalid_i,
	output logic                   awready_o,
	input  soc_bus_pkg::word_t     wdata_i,
	input  soc_bus_pkg::strb_t     wstrb_i,
	input  logic                   wvalid_i,
	output logic                   wready_o,
	output soc_bus_pkg::axi_resp_e bresp_o,
	output logic                   bvalid_o,
	input  logic                   bready_i,
	input  logic [31:0]            araddr_i,
	input  logic                   arvalid_i,
	output logic                   arready_o,
	output soc_bus_pkg::word_t     rdata_o,
	output soc_bus_pkg::axi_resp_e rresp_o,
	output logic                   rvalid_o,
	input  logic                   rready_i,
	// Board I/O and pixel stream
	input  logic [2:0]             btn_i,
	output logic [1:0]             led_o,
	output soc_bus_pkg::word_t     pixel_o,
	output logic                   pixel_valid_o,
	input  logic                   pixel_ready_i
);

	logic                   sys_rst;
	logic                   soft_reset;
	// Bridge memory master
	logic                   brg_req;
	logic                   brg_we;
	soc_bus_pkg::mem_addr_t brg_addr;
	soc_bus_pkg::strb_t     brg_strb;
	soc_bus_pkg::word_t     brg_wdata;
	logic                   brg_ack;
	soc_bus_pkg::word_t     brg_rdata;
	// Fetch memory master
	logic                   fch_req;
	soc_bus_pkg::mem_addr_t fch_addr;
	logic                   fch_ack;
	soc_bus_pkg::word_t     fch_rdata;
	// RAM side
	logic                   ram_req;
	logic                   ram_we;
	soc_bus_pkg::mem_addr_t ram_addr;
	soc_bus_pkg::strb_t     ram_strb;
	soc_bus_pkg::word_t     ram_wdata;
	logic                   ram_ack;
	soc_bus_pkg::word_t     ram_rdata;
	// CSR bus
	soc_csr_pkg::csr_addr_t csr_a;
	logic                   csr_we;
	soc_bus_pkg::word_t     csr_dw;
	soc_bus_pkg::word_t     csr_dr_sysctl;
	soc_bus_pkg::word_t     csr_dr_fetch;

	reset_gen u_reset_gen (
		.sys_clk,
		.trigger_reset,
		.soft_reset_i (soft_reset),
		.sys_rst_o    (sys_rst)
	);

	// --------------------------------------------------
	// Host bridge, CSR read data ORed from all peers
	// --------------------------------------------------
	axil_host_bridge u_bridge (
		.sys_clk,
		.sys_rst_i   (sys_rst),
		.awaddr_i,
		.awvalid_i,
		.awready_o,
		.wdata_i,
		.wstrb_i,
		.wvalid_i,
		.wready_o,
		.bresp_o,
		.bvalid_o,
		.bready_i,
		.araddr_i,
		.arvalid_i,
		.arready_o,
		.rdata_o,
		.rresp_o,
		.rvalid_o,
		.rready_i,
		.mem_req_o   (brg_req),
		.mem_we_o    (brg_we),
		.mem_addr_o  (brg_addr),
		.mem_strb_o  (brg_strb),
		.mem_wdata_o (brg_wdata),
		.mem_ack_i   (brg_ack),
		.mem_rdata_i (brg_rdata),
		.csr_a_o     (csr_a),
		.csr_we_o    (csr_we),
		.csr_dw_o    (csr_dw),
		.csr_dr_i    (csr_dr_sysctl | csr_dr_fetch)
	);

	// Scan-out is read-only and takes the high-priority slot
	mem_arbiter u_arbiter (
		.sys_clk,
		.sys_rst_i   (sys_rst),
		.m0_req_i    (fch_req),
		.m0_we_i     (1'b0),
		.m0_addr_i   (fch_addr),
		.m0_strb_i   ('0),
		.m0_wdata_i  ('0),
		.m0_ack_o    (fch_ack),
		.m0_rdata_o  (fch_rdata),
		.m1_req_i    (brg_req),
		.m1_we_i     (brg_we),
		.m1_addr_i   (brg_addr),
		.m1_strb_i   (brg_strb),
		.m1_wdata_i  (brg_wdata),
		.m1_ack_o    (brg_ack),
		.m1_rdata_o  (brg_rdata),
		.ram_req_o   (ram_req),
		.ram_we_o    (ram_we),
		.ram_addr_o  (ram_addr),
		.ram_strb_o  (ram_strb),
		.ram_wdata_o (ram_wdata),
		.ram_ack_i   (ram_ack),
		.ram_rdata_i (ram_rdata)
	);

	frame_ram u_frame_ram (
		.sys_clk,
		.req_i   (ram_req),
		.we_i    (ram_we),
		.addr_i  (ram_addr),
		.strb_i  (ram_strb),
		.wdata_i (ram_wdata),
		.ack_o   (ram_ack),
		.rdata_o (ram_rdata)
	);

	// --------------------------------------------------
	// CSR peers
	// --------------------------------------------------
	frame_fetch u_frame_fetch (
		.sys_clk,
		.sys_rst_i   (sys_rst),
		.csr_a_i     (csr_a),
		.csr_we_i    (csr_we),
		.csr_dw_i    (csr_dw),
		.csr_dr_o    (csr_dr_fetch),
		.mem_req_o   (fch_req),
		.mem_addr_o  (fch_addr),
		.mem_ack_i   (fch_ack),
		.mem_rdata_i (fch_rdata),
		.pixel_o,
		.pixel_valid_o,
		.pixel_ready_i
	);

	sys_ctl u_sys_ctl (
		.sys_clk,
		.sys_rst_i    (sys_rst),
		.csr_a_i      (csr_a),
		.csr_we_i     (csr_we),
		.csr_dw_i     (csr_dw),
		.csr_dr_o     (csr_dr_sysctl),
		.btn_i,
		.led_o,
		.soft_reset_o (soft_reset)
	);

endmodule

// ==== hdl/sys_ctl.sv ====
// System controller CSR block: buttons, LEDs, system ID and soft reset
`timescale 1ns/10ps
`include "soc_config.svh"

module sys_ctl (
	input  logic                   sys_clk,
	input  logic                   sys_rst_i,
	input  soc_csr_pkg::csr_addr_t csr_a_i,
	input  logic                   csr_we_i,
	input  soc_bus_pkg::word_t     csr_dw_i,
	output soc_bus_pkg::word_t     csr_dr_o,
	input  logic [2:0]             btn_i,
	output logic [1:0]             led_o,
	output logic                   soft_reset_o
);

	logic [2:0] btn_q;
	logic       sel;
	logic       wr;

	assign sel = (csr_a_i[5:2] == soc_csr_pkg::SYSCTL);
	assign wr  = sel && csr_we_i;

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			led_o        <= '0;
			soft_reset_o <= 1'b0;
		end else begin
			// Single-cycle pulse, the reset generator stretches it
			soft_reset_o <= wr && (csr_a_i[1:0] == soc_csr_pkg::SOFT_RESET);
			if (wr && (csr_a_i[1:0] == soc_csr_pkg::GPIO_OUT))
				led_o <= csr_dw_i[1:0];
		end
	end

	// --------------------------------------------------
	// Button sampling and readback
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		btn_q    <= btn_i;
		csr_dr_o <= '0;
		if (sel) begin
			case (csr_a_i[1:0])
				soc_csr_pkg::GPIO_IN:   csr_dr_o <= soc_bus_pkg::word_t'(btn_q);
				soc_csr_pkg::GPIO_OUT:  csr_dr_o <= soc_bus_pkg::word_t'(led_o);
				soc_csr_pkg::SYSTEM_ID: csr_dr_o <= `SYSTEM_ID;
				default:                csr_dr_o <= '0;
			endcase
		end
	end

endmodule

// ==== hdl/frame_fetch.sv ====
// Scan-out engine that streams a programmed block of frame words to the pixel port
`timescale 1ns/10ps
`include "soc_config.svh"

module frame_fetch (
	input  logic                   sys_clk,
	input  logic                   sys_rst_i,
	input  soc_csr_pkg::csr_addr_t csr_a_i,
	input  logic                   csr_we_i,
	input  soc_bus_pkg::word_t     csr_dw_i,
	output soc_bus_pkg::word_t     csr_dr_o,
	output logic                   mem_req_o,
	output soc_bus_pkg::mem_addr_t mem_addr_o,
	input  logic                   mem_ack_i,
	input  soc_bus_pkg::word_t     mem_rdata_i,
	output soc_bus_pkg::word_t     pixel_o,
	output logic                   pixel_valid_o,
	input  logic                   pixel_ready_i
);

	// Count can cover the whole RAM
	localparam int CNT_W = `MEM_AW + 1;

	soc_bus_pkg::fetch_state_e state_q;
	soc_bus_pkg::mem_addr_t    base_q;
	logic [CNT_W-1:0]          count_q;
	logic [CNT_W-1:0]          remain_q;
	logic                      sel;
	logic                      busy;
	logic                      start;

	assign sel       = (csr_a_i[5:2] == soc_csr_pkg::FETCH);
	assign busy      = (state_q != soc_bus_pkg::FE_IDLE);
	assign start     = sel && csr_we_i && (csr_a_i[1:0] == soc_csr_pkg::CTRL) &&
			csr_dw_i[0] && !busy && (count_q != '0);
	assign mem_req_o = (state_q == soc_bus_pkg::FE_REQ);

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state_q       <= soc_bus_pkg::FE_IDLE;
			pixel_valid_o <= 1'b0;
			base_q        <= '0;
			count_q       <= '0;
		end else begin
			if (sel && csr_we_i && (csr_a_i[1:0] == soc_csr_pkg::BASE))
				base_q <= csr_dw_i[`MEM_AW-1:0];
			if (sel && csr_we_i && (csr_a_i[1:0] == soc_csr_pkg::COUNT))
				count_q <= csr_dw_i[CNT_W-1:0];

			// --------------------------------------------------
			// One word in flight, held until the sink takes it
			// --------------------------------------------------
			case (state_q)
				soc_bus_pkg::FE_IDLE: begin
					if (start) begin
						mem_addr_o <= base_q;
						remain_q   <= count_q;
						state_q    <= soc_bus_pkg::FE_REQ;
					end
				end
				soc_bus_pkg::FE_REQ: begin
					if (mem_ack_i) begin
						pixel_o       <= mem_rdata_i;
						pixel_valid_o <= 1'b1;
						mem_addr_o    <= mem_addr_o + 1'b1;
						remain_q      <= remain_q - 1'b1;
						state_q       <= soc_bus_pkg::FE_HOLD;
					end
				end
				soc_bus_pkg::FE_HOLD: begin
					if (pixel_ready_i) begin
						pixel_valid_o <= 1'b0;
						if (remain_q == '0)
							state_q <= soc_bus_pkg::FE_IDLE;
						else
							state_q <= soc_bus_pkg::FE_REQ;
					end
				end
				default: state_q <= soc_bus_pkg::FE_IDLE;
			endcase
		end
	end

	// Readback, zero when another block is addressed
	always_ff @(posedge sys_clk) begin
		csr_dr_o <= '0;
		if (sel) begin
			case (csr_a_i[1:0])
				soc_csr_pkg::BASE:  csr_dr_o <= soc_bus_pkg::word_t'(base_q);
				soc_csr_pkg::COUNT: csr_dr_o <= soc_bus_pkg::word_t'(count_q);
				soc_csr_pkg::CTRL:  csr_dr_o <= soc_bus_pkg::word_t'(busy);
				default:            csr_dr_o <= '0;
			endcase
		end
	end

endmodule

// ==== hdl/frame_ram.sv ====
// Single-port frame RAM with byte strobes and a registered acknowledge
`timescale 1ns/10ps
`include "soc_config.svh"

module frame_ram (
	input  logic                   sys_clk,
	input  logic                   req_i,
	input  logic                   we_i,
	input  soc_bus_pkg::mem_addr_t addr_i,
	input  soc_bus_pkg::strb_t     strb_i,
	input  soc_bus_pkg::word_t     wdata_i,
	output logic                   ack_o,
	output soc_bus_pkg::word_t     rdata_o
);

	localparam int DEPTH = 1 << `MEM_AW;

	soc_bus_pkg::word_t mem [DEPTH];

	// A request still high in the acknowledge cycle is not served twice
	always_ff @(posedge sys_clk) begin
		ack_o <= req_i && !ack_o;
		if (req_i && !ack_o) begin
			for (int b = 0; b < 4; b++) begin
				if (we_i && strb_i[b]) begin
					mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
				end
			end
			rdata_o <= mem[addr_i];
		end
	end

endmodule

// ==== hdl/mem_arbiter.sv ====
// Fixed-priority arbiter for two frame memory masters, fetch engine first
`timescale 1ns/10ps

module mem_arbiter (
	input  logic                   sys_clk,
	input  logic                   sys_rst_i,
	// Master 0, scan-out fetch
	input  logic                   m0_req_i,
	input  logic                   m0_we_i,
	input  soc_bus_pkg::mem_addr_t m0_addr_i,
	input  soc_bus_pkg::strb_t     m0_strb_i,
	input  soc_bus_pkg::word_t     m0_wdata_i,
	output logic                   m0_ack_o,
	output soc_bus_pkg::word_t     m0_rdata_o,
	// Master 1, host bridge
	input  logic                   m1_req_i,
	input  logic                   m1_we_i,
	input  soc_bus_pkg::mem_addr_t m1_addr_i,
	input  soc_bus_pkg::strb_t     m1_strb_i,
	input  soc_bus_pkg::word_t     m1_wdata_i,
	output logic                   m1_ack_o,
	output soc_bus_pkg::word_t     m1_rdata_o,
	// Frame RAM
	output logic                   ram_req_o,
	output logic                   ram_we_o,
	output soc_bus_pkg::mem_addr_t ram_addr_o,
	output soc_bus_pkg::strb_t     ram_strb_o,
	output soc_bus_pkg::word_t     ram_wdata_o,
	input  logic                   ram_ack_i,
	input  soc_bus_pkg::word_t     ram_rdata_i
);

	logic grant_q;
	// Set selects master 1
	logic grant_m1_q;

	// New grants only while idle, released by the RAM acknowledge
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			grant_q <= 1'b0;
		end else if (!grant_q) begin
			grant_q    <= m0_req_i || m1_req_i;
			grant_m1_q <= !m0_req_i;
		end else if (ram_ack_i) begin
			grant_q <= 1'b0;
		end
	end

	assign ram_req_o   = grant_q;
	assign ram_we_o    = grant_m1_q ? m1_we_i : m0_we_i;
	assign ram_addr_o  = grant_m1_q ? m1_addr_i : m0_addr_i;
	assign ram_strb_o  = grant_m1_q ? m1_strb_i : m0_strb_i;
	assign ram_wdata_o = grant_m1_q ? m1_wdata_i : m0_wdata_i;

	// Only the granted master sees the acknowledge and data
	assign m0_ack_o   = grant_q && !grant_m1_q && ram_ack_i;
	assign m1_ack_o   = grant_q && grant_m1_q && ram_ack_i;
	assign m0_rdata_o = grant_m1_q ? '0 : ram_rdata_i;
	assign m1_rdata_o = grant_m1_q ? ram_rdata_i : '0;

endmodule

// ==== hdl/axil_host_bridge.sv ====
// AXI4-Lite slave that turns host accesses into frame memory requests or CSR cycles
`timescale 1ns/10ps
`include "soc_config.svh"

module axil_host_bridge (
	input  logic                    sys_clk,
	input  logic                    sys_rst_i,
	// AXI4-Lite slave
	input  logic [31:0]             awaddr_i,
	input  logic                    awvalid_i,
	output logic                    awready_o,
	input  soc_bus_pkg::word_t      wdata_i,
	input  soc_bus_pkg::strb_t      wstrb_i,
	input  logic                    wvalid_i,
	output logic                    wready_o,
	output soc_bus_pkg::axi_resp_e  bresp_o,
	output logic                    bvalid_o,
	input  logic                    bready_i,
	input  logic [31:0]             araddr_i,
	input  logic                    arvalid_i,
	output logic                    arready_o,
	output soc_bus_pkg::word_t      rdata_o,
	output soc_bus_pkg::axi_resp_e  rresp_o,
	output logic                    rvalid_o,
	input  logic                    rready_i,
	// Frame memory master
	output logic                    mem_req_o,
	output logic                    mem_we_o,
	output soc_bus_pkg::mem_addr_t  mem_addr_o,
	output soc_bus_pkg::strb_t      mem_strb_o,
	output soc_bus_pkg::word_t      mem_wdata_o,
	input  logic                    mem_ack_i,
	input  soc_bus_pkg::word_t      mem_rdata_i,
	// CSR master
	output soc_csr_pkg::csr_addr_t  csr_a_o,
	output logic                    csr_we_o,
	output soc_bus_pkg::word_t      csr_dw_o,
	input  soc_bus_pkg::word_t      csr_dr_i
);

	soc_bus_pkg::bridge_state_e state_q;
	logic        csr_wait_q;
	logic [31:0] hs_addr;
	logic        hs_csr;
	logic        hs_bad;

	// Address of whichever channel completes its handshake
	assign hs_addr = awready_o ? awaddr_i : araddr_i;
	assign hs_csr  = hs_addr[`CSR_REGION_BIT];
	// Memory region bits above the RAM must be zero
	assign hs_bad  = (hs_addr[`CSR_REGION_BIT-1:`MEM_AW+2] != '0);

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state_q   <= soc_bus_pkg::BR_IDLE;
			awready_o <= 1'b0;
			wready_o  <= 1'b0;
			arready_o <= 1'b0;
			bvalid_o  <= 1'b0;
			rvalid_o  <= 1'b0;
			mem_req_o <= 1'b0;
			csr_we_o  <= 1'b0;
		end else begin
			case (state_q)
				// --------------------------------------------------
				// Accept one transaction, writes first
				// --------------------------------------------------
				soc_bus_pkg::BR_IDLE: begin
					if (awready_o || arready_o) begin
						awready_o   <= 1'b0;
						wready_o    <= 1'b0;
						arready_o   <= 1'b0;
						mem_we_o    <= awready_o;
						mem_addr_o  <= hs_addr[`MEM_AW+1:2];
						mem_strb_o  <= wstrb_i;
						mem_wdata_o <= wdata_i;
						csr_a_o     <= hs_addr[7:2];
						csr_dw_o    <= wdata_i;
						csr_wait_q  <= 1'b0;
						if (hs_csr) begin
							csr_we_o <= awready_o;
							state_q  <= soc_bus_pkg::BR_CSR_WAIT;
						end else if (hs_bad && awready_o) begin
							bresp_o  <= soc_bus_pkg::DECERR;
							bvalid_o <= 1'b1;
							state_q  <= soc_bus_pkg::BR_RESP_W;
						end else if (hs_bad) begin
							rresp_o  <= soc_bus_pkg::DECERR;
							rdata_o  <= '0;
							rvalid_o <= 1'b1;
							state_q  <= soc_bus_pkg::BR_RESP_R;
						end else begin
							mem_req_o <= 1'b1;
							state_q   <= soc_bus_pkg::BR_MEM_WAIT;
						end
					end else if (awvalid_i && wvalid_i) begin
						awready_o <= 1'b1;
						wready_o  <= 1'b1;
					end else if (arvalid_i) begin
						arready_o <= 1'b1;
					end
				end
				soc_bus_pkg::BR_MEM_WAIT: begin
					if (mem_ack_i) begin
						mem_req_o <= 1'b0;
						if (mem_we_o) begin
							bresp_o  <= soc_bus_pkg::OKAY;
							bvalid_o <= 1'b1;
							state_q  <= soc_bus_pkg::BR_RESP_W;
						end else begin
							rdata_o  <= mem_rdata_i;
							rresp_o  <= soc_bus_pkg::OKAY;
							rvalid_o <= 1'b1;
							state_q  <= soc_bus_pkg::BR_RESP_R;
						end
					end
				end
				// Writes finish after one cycle, reads wait for the peer data
				soc_bus_pkg::BR_CSR_WAIT: begin
					csr_we_o <= 1'b0;
					if (mem_we_o) begin
						bresp_o  <= soc_bus_pkg::OKAY;
						bvalid_o <= 1'b1;
						state_q  <= soc_bus_pkg::BR_RESP_W;
					end else if (csr_wait_q) begin
						rdata_o  <= csr_dr_i;
						rresp_o  <= soc_bus_pkg::OKAY;
						rvalid_o <= 1'b1;
						state_q  <= soc_bus_pkg::BR_RESP_R;
					end else begin
						csr_wait_q <= 1'b1;
					end
				end
				// --------------------------------------------------
				// Hold the response until the host takes it
				// --------------------------------------------------
				soc_bus_pkg::BR_RESP_W: begin
					if (bready_i) begin
						bvalid_o <= 1'b0;
						state_q  <= soc_bus_pkg::BR_IDLE;
					end
				end
				soc_bus_pkg::BR_RESP_R: begin
					if (rready_i) begin
						rvalid_o <= 1'b0;
						state_q  <= soc_bus_pkg::BR_IDLE;
					end
				end
				default: state_q <= soc_bus_pkg::BR_IDLE;
			endcase
		end
	end

endmodule

// ==== hdl/reset_gen.sv ====
// Reset stretcher that holds the core reset for a fixed time after any reset request
`timescale 1ns/10ps
`include "soc_config.svh"

module reset_gen (
	input  logic sys_clk,
	input  logic trigger_reset,
	input  logic soft_reset_i,
	output logic sys_rst_o
);

	localparam int CNT_W = $clog2(`RST_HOLD + 1);

	logic [CNT_W-1:0] hold_cnt;

	// Either request reloads the counter, reset follows it down to zero
	always_ff @(posedge sys_clk) begin
		if (trigger_reset || soft_reset_i) begin
			hold_cnt <= CNT_W'(`RST_HOLD);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
		sys_rst_o <= (hold_cnt != '0);
	end

endmodule

// ==== hdl/soc_csr_pkg.sv ====
// CSR bus address map: block selects and register indices of each peer
package soc_csr_pkg;

	// Block field, CSR address bits 5:2
	typedef enum logic [3:0] {
		SYSCTL = 4'd1,
		FETCH  = 4'd3
	} csr_block_e;

	typedef enum logic [1:0] {
		GPIO_IN    = 2'd0,
		GPIO_OUT   = 2'd1,
		SYSTEM_ID  = 2'd2,
		SOFT_RESET = 2'd3
	} sysctl_reg_e;

	typedef enum logic [1:0] {
		BASE  = 2'd0,
		COUNT = 2'd1,
		CTRL  = 2'd2
	} fetch_reg_e;

	// Block in bits 5:2, register in bits 1:0
	typedef logic [5:0] csr_addr_t;

endpackage

// ==== hdl/soc_bus_pkg.sv ====
// Bus types shared by the host bridge, the memory arbiter, the RAM and the fetch engine
`include "soc_config.svh"

package soc_bus_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] strb_t;
	typedef logic [`MEM_AW-1:0] mem_addr_t;

	// AXI4-Lite response codes in use
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		DECERR = 2'b11
	} axi_resp_e;

	// Host bridge transaction states
	typedef enum logic [2:0] {
		BR_IDLE,
		BR_MEM_WAIT,
		BR_CSR_WAIT,
		BR_RESP_W,
		BR_RESP_R
	} bridge_state_e;

	// Scan-out states
	typedef enum logic [1:0] {
		FE_IDLE,
		FE_REQ,
		FE_HOLD
	} fetch_state_e;

endpackage

// ==== hdl/soc_config.svh ====
// Build constants for the video SoC core: memory size, reset hold, ID, address map
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Frame RAM word-address width, 1024 words
`define MEM_AW 10

// Core reset hold time in sys_clk cycles
`define RST_HOLD 16

// Value returned by the system controller ID register
`define SYSTEM_ID 32'h4D4F4E45

// AXI address bit that selects the CSR region over memory
`define CSR_REGION_BIT 16

`endif
